// ==== Bender.yml ====
package:
  name: mem_system

sources:
  - include_dirs:
      - src
    files:
      - src/mem_system_pkg.sv
      - src/cache_way.sv
      - src/way_merge.sv
      - src/cache_controller.sv
      - src/banked_memory.sv
      - src/mem_system.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/mem_system_checker.sv
      - tests/mem_system_tb.sv

// ==== project.f ====
+incdir+src
src/mem_system_pkg.sv
src/cache_way.sv
src/way_merge.sv
src/cache_controller.sv
src/banked_memory.sv
src/mem_system.sv
tests/mem_system_checker.sv
tests/mem_system_tb.sv

// ==== src/banked_memory.sv ====
`include "mem_system_config.svh"

module banked_memory
	import mem_system_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  mem_req_t mem_req,
	output logic     credit_return,
	output mem_rsp_t mem_rsp
);

	localparam int ROWS  = 1 << (`ADDR_W - `OFFSET_W);
	localparam int PTR_W = $clog2(`MEM_CREDITS);
	localparam int CNT_W = $clog2(`MEM_CREDITS + 1);
	localparam int LAT   = `MEM_LATENCY;

	mem_req_t            queue [`MEM_CREDITS];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic                pop;
	logic                rd_pop;
	mem_req_t            head;
	logic [`OFFSET_W-2:0] head_word;
	logic [`ADDR_W-`OFFSET_W-1:0] head_row;

	// Bank picked by word offset, row by line address
	logic [`DATA_W-1:0]  bank [`WORDS_PER_LINE][ROWS] = '{default: '0};

	logic [LAT-1:0]      pipe_vld;
	logic [`OFFSET_W-2:0] pipe_off  [LAT];
	logic [`DATA_W-1:0]  pipe_data [LAT];

	assign pop       = (count != '0);   // One pop per cycle
	assign head      = queue[rd_ptr];
	assign rd_pop    = pop & (head.op == MEM_READ);
	assign head_word = head.addr[`OFFSET_W-1:1];
	assign head_row  = head.addr[`ADDR_W-1:`OFFSET_W];

	assign credit_return = pop;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			pipe_vld <= '0;
		end else begin
			if (mem_req.valid)
				wr_ptr <= (wr_ptr == PTR_W'(`MEM_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(`MEM_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			count    <= count + CNT_W'(mem_req.valid) - CNT_W'(pop);
			pipe_vld <= {pipe_vld[LAT-2:0], rd_pop};
		end
	end

	always_ff @(posedge clk) begin
		if (mem_req.valid)
			queue[wr_ptr] <= mem_req;
		if (pop && head.op == MEM_WRITE)
			bank[head_word][head_row] <= head.wdata;   // Writes retire on pop
		pipe_off[0]  <= head_word;
		pipe_data[0] <= bank[head_word][head_row];
		for (int i = 1; i < LAT; i++) begin
			pipe_off[i]  <= pipe_off[i-1];
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	always_comb begin
		mem_rsp.valid  = pipe_vld[LAT-1];
		mem_rsp.offset = pipe_off[LAT-1];
		mem_rsp.rdata  = pipe_data[LAT-1];
	end

endmodule

// ==== src/cache_controller.sv ====
`include "mem_system_config.svh"

module cache_controller
	import mem_system_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu_req_t              cpu_req,
	output cpu_rsp_t              cpu_rsp,
	output logic                  stall,
	output logic                  err,
	output way_ctrl_t             way_ctrl,
	output logic [`NUM_WAYS-1:0]  way_en,
	input  logic                  hit,
	input  logic [`NUM_WAYS-1:0]  valid,
	input  logic [`NUM_WAYS-1:0]  dirty,
	input  logic [`DATA_W-1:0]    rdata,
	input  logic [`TAG_W-1:0]     wb_tag,
	output mem_req_t              mem_req,
	input  logic                  credit_return,
	input  mem_rsp_t              mem_rsp
);

	localparam int CRED_W = $clog2(`MEM_CREDITS + 1);
	localparam int WSEL_W = `OFFSET_W - 1;
	localparam logic [WSEL_W-1:0] LAST_WORD = WSEL_W'(`WORDS_PER_LINE - 1);

	ctrl_state_e state;
	ctrl_state_e next_state;
	cpu_req_t    req_q;

	logic                  victim;
	logic                  fill_way;
	logic                  fill_way_nxt;
	logic [`NUM_WAYS-1:0]  fill_en;
	logic [CRED_W-1:0]     credits;
	logic                  have_credit;
	logic                  new_req;
	logic                  accept;
	logic                  fill_wr;
	logic [WSEL_W-1:0]     wb_cnt;
	logic [WSEL_W-1:0]     req_cnt;
	logic [WSEL_W-1:0]     rsp_cnt;
	logic [`TAG_W-1:0]     req_tag;
	logic [`INDEX_W-1:0]   req_index;
	logic [WSEL_W-1:0]     req_word;

	assign req_tag   = req_q.addr[`ADDR_W-1 -: `TAG_W];
	assign req_index = req_q.addr[`OFFSET_W +: `INDEX_W];
	assign req_word  = req_q.addr[`OFFSET_W-1:1];

	assign new_req     = cpu_req.rd | cpu_req.wr;
	assign accept      = new_req & ((state == IDLE) | cpu_rsp.done);   // Back-to-back allowed
	assign have_credit = (credits != '0);
	assign fill_en     = `NUM_WAYS'(1) << fill_way;
	assign fill_wr     = ((state == FILL_REQ) | (state == FILL_WAIT)) & mem_rsp.valid;

	assign stall = (state != IDLE) & ~cpu_rsp.done;
	assign err   = (state == ERROR);

	// First invalid way, else the victim
	always_comb begin
		if (!valid[0])
			fill_way_nxt = 1'b0;
		else if (!valid[1])
			fill_way_nxt = 1'b1;
		else
			fill_way_nxt = victim;
	end

	always_comb begin
		next_state     = state;
		way_en         = '0;
		way_ctrl       = '0;
		way_ctrl.index = req_index;
		way_ctrl.tag   = req_tag;
		way_ctrl.offset = req_word;
		way_ctrl.wdata = req_q.wdata;
		mem_req        = '0;
		cpu_rsp        = '0;
		cpu_rsp.rdata  = rdata;

		case (state)
			IDLE: begin
				if (new_req)
					next_state = COMPARE;
			end
			COMPARE: begin
				way_en         = '1;
				way_ctrl.enable = 1'b1;
				way_ctrl.comp  = 1'b1;
				way_ctrl.write = req_q.wr;
				if (hit) begin
					cpu_rsp.done = 1'b1;
					cpu_rsp.hit  = 1'b1;
					next_state   = new_req ? COMPARE : IDLE;
				end else begin
					next_state = SELECT;
				end
			end
			SELECT: begin
				way_en          = '1;   // Status read only
				way_ctrl.enable = 1'b1;
				if (valid[fill_way_nxt] && dirty[fill_way_nxt])
					next_state = WRITEBACK;
				else
					next_state = FILL_REQ;
			end
			WRITEBACK: begin
				way_en          = fill_en;
				way_ctrl.enable = 1'b1;
				way_ctrl.offset = wb_cnt;
				mem_req.valid   = have_credit;
				mem_req.op      = MEM_WRITE;
				mem_req.addr    = {wb_tag, req_index, wb_cnt, 1'b0};
				mem_req.wdata   = rdata;
				if (have_credit && wb_cnt == LAST_WORD)
					next_state = FILL_REQ;
			end
			FILL_REQ: begin
				mem_req.valid = have_credit;
				mem_req.op    = MEM_READ;
				mem_req.addr  = {req_tag, req_index, req_cnt, 1'b0};
				if (have_credit && req_cnt == LAST_WORD)
					next_state = FILL_WAIT;
			end
			FILL_WAIT: begin
				if (mem_rsp.valid && rsp_cnt == LAST_WORD)
					next_state = REFILL_DONE;
			end
			REFILL_DONE: begin
				way_en          = '1;   // Replay the original access
				way_ctrl.enable = 1'b1;
				way_ctrl.comp   = 1'b1;
				way_ctrl.write  = req_q.wr;
				cpu_rsp.done    = 1'b1;
				next_state      = new_req ? COMPARE : IDLE;
			end
			ERROR: begin
				next_state = ERROR;   // Held until reset
			end
			default: begin
				next_state = ERROR;
			end
		endcase

		// Returned words land in the chosen way, also while requests still go out
		if (fill_wr) begin
			way_en            = fill_en;
			way_ctrl.enable   = 1'b1;
			way_ctrl.comp     = 1'b0;
			way_ctrl.write    = 1'b1;
			way_ctrl.valid_in = 1'b1;
			way_ctrl.offset   = mem_rsp.offset;
			way_ctrl.wdata    = mem_rsp.rdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			victim   <= 1'b0;
			fill_way <= 1'b0;
			credits  <= CRED_W'(`MEM_CREDITS);
			wb_cnt   <= '0;
			req_cnt  <= '0;
			rsp_cnt  <= '0;
		end else begin
			state   <= next_state;
			credits <= credits - CRED_W'(mem_req.valid) + CRED_W'(credit_return);
			if (state == COMPARE || state == REFILL_DONE)
				victim <= ~victim;   // Toggles on every compare
			if (state == SELECT)
				fill_way <= fill_way_nxt;
			if (state == WRITEBACK && mem_req.valid)
				wb_cnt <= wb_cnt + 1'b1;   // Wraps to zero after the last word
			if (state == FILL_REQ && mem_req.valid)
				req_cnt <= req_cnt + 1'b1;
			if (fill_wr)
				rsp_cnt <= rsp_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			req_q <= cpu_req;
	end

endmodule

// ==== src/cache_way.sv ====
`include "mem_system_config.svh"

module cache_way
	import mem_system_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  way_ctrl_t ctrl,
	input  logic      way_en,
	output way_stat_t stat
);

	localparam int SETS = 1 << `INDEX_W;

	logic [`TAG_W-1:0]  tag_mem  [SETS];
	logic [`DATA_W-1:0] data_mem [SETS][`WORDS_PER_LINE];
	logic [SETS-1:0]    valid_q;
	logic [SETS-1:0]    dirty_q;

	logic              sel;
	logic              tag_eq;
	logic              hit;
	logic              store_word;
	logic              fill_wr;
	logic [`TAG_W-1:0] cur_tag;

	assign sel     = ctrl.enable & way_en;
	assign cur_tag = tag_mem[ctrl.index];
	assign tag_eq  = (cur_tag == ctrl.tag);
	assign hit     = sel & ctrl.comp & valid_q[ctrl.index] & tag_eq;

	// Compare write only lands on a hit, a plain write always lands
	assign fill_wr    = sel & ctrl.write & ~ctrl.comp;
	assign store_word = fill_wr | (ctrl.write & hit);

	always_comb begin
		stat.hit   = hit;
		stat.valid = valid_q[ctrl.index];   // Needed by victim choice
		stat.dirty = dirty_q[ctrl.index];
		stat.tag   = sel ? cur_tag : '0;    // Zero lets way_merge OR the ways
		stat.rdata = sel ? data_mem[ctrl.index][ctrl.offset] : '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill_wr) begin
			valid_q[ctrl.index] <= ctrl.valid_in;
			dirty_q[ctrl.index] <= 1'b0;   // Line now matches memory
		end else if (ctrl.write && hit) begin
			dirty_q[ctrl.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (store_word) begin
			data_mem[ctrl.index][ctrl.offset] <= ctrl.wdata;
		end
		if (fill_wr) begin
			tag_mem[ctrl.index] <= ctrl.tag;
		end
	end

endmodule

// ==== src/mem_system.sv ====
`include "mem_system_config.svh"

module mem_system
	import mem_system_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  cpu_req_t cpu_req,
	output cpu_rsp_t cpu_rsp,
	output logic     stall,
	output logic     err
);

	way_ctrl_t            way_ctrl;
	logic [`NUM_WAYS-1:0] way_en;
	way_stat_t            way_stat [`NUM_WAYS];

	logic                 hit;
	logic [`NUM_WAYS-1:0] valid;
	logic [`NUM_WAYS-1:0] dirty;
	logic [`DATA_W-1:0]   rdata;
	logic [`TAG_W-1:0]    wb_tag;

	mem_req_t             mem_req;
	logic                 credit_return;
	mem_rsp_t             mem_rsp;

	cache_controller u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.cpu_req       (cpu_req),
		.cpu_rsp       (cpu_rsp),
		.stall         (stall),
		.err           (err),
		.way_ctrl      (way_ctrl),
		.way_en        (way_en),
		.hit           (hit),
		.valid         (valid),
		.dirty         (dirty),
		.rdata         (rdata),
		.wb_tag        (wb_tag),
		.mem_req       (mem_req),
		.credit_return (credit_return),
		.mem_rsp       (mem_rsp)
	);

	for (genvar g = 0; g < `NUM_WAYS; g++) begin : g_way
		cache_way u_way (
			.clk    (clk),
			.rst_n  (rst_n),
			.ctrl   (way_ctrl),
			.way_en (way_en[g]),
			.stat   (way_stat[g])
		);
	end

	way_merge u_merge (
		.stat    (way_stat),
		.hit     (hit),
		.hit_way (),
		.valid   (valid),
		.dirty   (dirty),
		.rdata   (rdata),
		.wb_tag  (wb_tag)
	);

	banked_memory u_mem (
		.clk           (clk),
		.rst_n         (rst_n),
		.mem_req       (mem_req),
		.credit_return (credit_return),
		.mem_rsp       (mem_rsp)
	);

endmodule

// ==== src/mem_system_config.svh ====
`ifndef MEM_SYSTEM_CONFIG_SVH
`define MEM_SYSTEM_CONFIG_SVH

`define ADDR_W         16   // Byte address
`define DATA_W         16
`define INDEX_W        5    // 32 sets
`define WORDS_PER_LINE 4
`define OFFSET_W       3    // Byte offset bits within a line
`define TAG_W          (`ADDR_W - `INDEX_W - `OFFSET_W)

`define MEM_LATENCY    4    // Queue pop to read response
`define MEM_CREDITS    2    // Queue depth and initial credits

`define NUM_WAYS       2

`endif

// ==== src/mem_system_pkg.sv ====
`include "mem_system_config.svh"

package mem_system_pkg;

	typedef struct packed {
		logic               rd;
		logic               wr;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic               done;
		logic               hit;
		logic [`DATA_W-1:0] rdata;
	} cpu_rsp_t;

	// Access command, each way qualifies enable with its own way_en bit
	typedef struct packed {
		logic                  enable;
		logic                  comp;
		logic                  write;
		logic                  valid_in;
		logic [`INDEX_W-1:0]   index;
		logic [`TAG_W-1:0]     tag;
		logic [`OFFSET_W-2:0]  offset;   // Word select
		logic [`DATA_W-1:0]    wdata;
	} way_ctrl_t;

	typedef struct packed {
		logic               hit;
		logic               valid;
		logic               dirty;
		logic [`TAG_W-1:0]  tag;
		logic [`DATA_W-1:0] rdata;
	} way_stat_t;

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_op_e;

	typedef struct packed {
		logic               valid;
		mem_op_e            op;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic                 valid;
		logic [`OFFSET_W-2:0] offset;   // Word select of the returned word
		logic [`DATA_W-1:0]   rdata;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		COMPARE,
		SELECT,
		WRITEBACK,
		FILL_REQ,
		FILL_WAIT,
		REFILL_DONE,
		ERROR
	} ctrl_state_e;

endpackage

// ==== src/way_merge.sv ====
`include "mem_system_config.svh"

module way_merge
	import mem_system_pkg::*;
(
	input  way_stat_t             stat [`NUM_WAYS],
	output logic                  hit,
	output logic                  hit_way,
	output logic [`NUM_WAYS-1:0]  valid,
	output logic [`NUM_WAYS-1:0]  dirty,
	output logic [`DATA_W-1:0]    rdata,
	output logic [`TAG_W-1:0]     wb_tag
);

	logic [`DATA_W-1:0] any_rdata;
	logic [`TAG_W-1:0]  any_tag;

	always_comb begin
		hit       = 1'b0;
		hit_way   = 1'b0;
		any_rdata = '0;
		any_tag   = '0;
		for (int i = 0; i < `NUM_WAYS; i++) begin
			valid[i]  = stat[i].valid;
			dirty[i]  = stat[i].dirty;
			any_rdata = any_rdata | stat[i].rdata;   // Disabled ways read as zero
			any_tag   = any_tag | stat[i].tag;
			if (stat[i].hit && !hit) begin
				hit     = 1'b1;
				hit_way = 1'(i);   // Lowest hitting way wins
			end
		end
		rdata  = hit ? stat[hit_way].rdata : any_rdata;
		wb_tag = any_tag;
	end

endmodule

// ==== tests/mem_system_checker.sv ====
`include "mem_system_config.svh"

module mem_system_checker (
	input logic                                 clk,
	input logic                                 rst_n,
	input logic                                 mem_valid,
	input logic [$clog2(`MEM_CREDITS + 1)-1:0]  credits,
	input logic                                 err,
	input logic                                 stall,
	input logic                                 done
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;   // Sampled by the testbench monitor

	// No request may leave without a credit
	no_request_without_credit: assert property (
		@(posedge clk) disable iff (!rst_n) mem_valid |-> (credits != '0)
	) else begin
		fail_count++;
		$error("memory request issued while the credit count was zero");
	end

	credit_count_bounded: assert property (
		@(posedge clk) disable iff (!rst_n) credits <= `MEM_CREDITS
	) else begin
		fail_count++;
		$error("credit count exceeds the memory queue depth");
	end

	no_error_state: assert property (
		@(posedge clk) disable iff (!rst_n) !err
	) else begin
		fail_count++;
		$error("controller reached its error state");
	end

	no_stall_on_done: assert property (
		@(posedge clk) disable iff (!rst_n) done |-> !stall
	) else begin
		fail_count++;
		$error("stall is high in the cycle that done is high");
	end

endmodule

bind cache_controller mem_system_checker u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.mem_valid (mem_req.valid),
	.credits   (credits),
	.err       (err),
	.stall     (stall),
	.done      (cpu_rsp.done)
);

// ==== tests/mem_system_tb.sv ====
`include "mem_system_config.svh"

module mem_system_tb
	import mem_system_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SETS    = 1 << `INDEX_W;
	localparam int TAG_W   = `TAG_W;
	localparam int INDEX_W = `INDEX_W;
	localparam int WSEL_W  = `OFFSET_W - 1;
	localparam int TIMEOUT = 200;   // Cycles per wait

	logic     clk;
	logic     rst_n;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;
	logic     stall;
	logic     err;

	// Shadow memory and shadow cache for the reference model
	logic [`DATA_W-1:0] shadow_mem [1 << (`ADDR_W - 1)];
	logic [TAG_W-1:0]   ref_tag    [`NUM_WAYS][SETS];
	logic               ref_valid  [`NUM_WAYS][SETS];
	logic               ref_dirty  [`NUM_WAYS][SETS];
	logic [`DATA_W-1:0] ref_data   [`NUM_WAYS][SETS][`WORDS_PER_LINE];
	logic               ref_victim;

	cpu_rsp_t exp_q  [$];
	string    name_q [$];
	logic     rd_q   [$];

	mem_system u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.cpu_req (cpu_req),
		.cpu_rsp (cpu_rsp),
		.stall   (stall),
		.err     (err)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_failure();
		$display("** FAIL **");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_hit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s hit: expected %0b, actual %0b", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_rdata(input string name, input logic [`DATA_W-1:0] exp,
			input logic [`DATA_W-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s rdata: expected 0x%04h, actual 0x%04h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_stall(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s stall: expected %0b, actual %0b", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[ERROR] %s latency: expected %0d, actual %0d", name, exp, act);
			report_failure();
		end
	endtask

	function automatic logic line_cached(input logic [`ADDR_W-1:0] addr);
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] idx;
		tag = addr[`ADDR_W-1 -: TAG_W];
		idx = addr[`OFFSET_W +: INDEX_W];
		return (ref_valid[0][idx] && ref_tag[0][idx] == tag) ||
			(ref_valid[1][idx] && ref_tag[1][idx] == tag);
	endfunction

	// Two-way write-back cache, victim toggles on every compare and replay
	function automatic cpu_rsp_t predict_access(input cpu_req_t req);
		cpu_rsp_t           rsp;
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] idx;
		logic [WSEL_W-1:0]  word;
		int                 way;
		rsp        = '0;
		rsp.done   = 1'b1;
		tag        = req.addr[`ADDR_W-1 -: TAG_W];
		idx        = req.addr[`OFFSET_W +: INDEX_W];
		word       = req.addr[`OFFSET_W-1:1];
		ref_victim = ~ref_victim;
		way        = -1;
		for (int w = `NUM_WAYS - 1; w >= 0; w--)
			if (ref_valid[w][idx] && ref_tag[w][idx] == tag)
				way = w;
		rsp.hit = (way >= 0);
		if (way < 0) begin
			if (!ref_valid[0][idx])
				way = 0;
			else if (!ref_valid[1][idx])
				way = 1;
			else
				way = ref_victim;
			if (ref_valid[way][idx] && ref_dirty[way][idx])
				for (int i = 0; i < `WORDS_PER_LINE; i++)
					shadow_mem[{ref_tag[way][idx], idx, WSEL_W'(i)}] = ref_data[way][idx][i];
			for (int i = 0; i < `WORDS_PER_LINE; i++)
				ref_data[way][idx][i] = shadow_mem[{tag, idx, WSEL_W'(i)}];
			ref_tag[way][idx]   = tag;
			ref_valid[way][idx] = 1'b1;
			ref_dirty[way][idx] = 1'b0;
			ref_victim          = ~ref_victim;   // Replay compare
		end
		rsp.rdata = ref_data[way][idx][word];
		if (req.wr) begin
			ref_data[way][idx][word] = req.wdata;
			ref_dirty[way][idx]      = 1'b1;
		end
		return rsp;
	endfunction

	task automatic cpu_access(input string name, input logic wr, input logic [`ADDR_W-1:0] addr,
			input logic [`DATA_W-1:0] wdata, output cpu_rsp_t rsp, output int cycles);
		cpu_req_t req;
		int       waited;
		waited = 0;
		@(negedge clk);
		while (stall && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (stall) begin
			$display("Timeout: stall never dropped before %s", name);
			report_failure();
		end
		req.rd    = ~wr;
		req.wr    = wr;
		req.addr  = addr;
		req.wdata = wdata;
		exp_q.push_back(predict_access(req));
		name_q.push_back(name);
		rd_q.push_back(~wr);
		cpu_req = req;
		@(negedge clk);
		cpu_req = '0;
		cycles  = 1;   // First falling edge after acceptance
		while (!cpu_rsp.done && cycles < TIMEOUT) begin
			check_stall(name, 1'b1, stall);   // Held until done
			@(negedge clk);
			cycles++;
		end
		if (!cpu_rsp.done) begin
			$display("Timeout: done never came for %s", name);
			report_failure();
		end
		rsp = cpu_rsp;
	endtask

	always @(negedge clk) begin : compare_rsp
		cpu_rsp_t expected;
		string    name;
		logic     is_rd;
		if (rst_n && u_dut.u_ctrl.u_checker.fail_count != 0) begin
			$display("A bound assertion on the controller failed");
			report_failure();
		end else if (rst_n && err !== 1'b0) begin
			$display("The DUT raised its error flag");
			report_failure();
		end else if (rst_n && cpu_rsp.done) begin
			if (exp_q.size() == 0) begin
				$display("The DUT raised done with no request outstanding");
				report_failure();
			end else begin
				expected = exp_q.pop_front();
				name     = name_q.pop_front();
				is_rd    = rd_q.pop_front();
				check_hit(name, expected.hit, cpu_rsp.hit);
				if (is_rd)
					check_rdata(name, expected.rdata, cpu_rsp.rdata);
			end
		end
	end

	initial begin : stimulus
		cpu_rsp_t           rsp;
		int                 cycles;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
		logic [TAG_W-1:0]   evict_tag;
		logic               wr;
		cpu_req    = '0;
		rst_n      = 1'b0;
		ref_victim = 1'b0;
		for (int i = 0; i < (1 << (`ADDR_W - 1)); i++)
			shadow_mem[i] = '0;
		for (int w = 0; w < `NUM_WAYS; w++)
			for (int s = 0; s < SETS; s++) begin
				ref_valid[w][s] = 1'b0;
				ref_dirty[w][s] = 1'b0;
			end
		void'($urandom(32'hee408c81));
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		// Cold miss, then a hit done one cycle after acceptance
		cpu_access("cold_miss", 1'b0, 16'h0100, '0, rsp, cycles);
		check_hit("cold_miss", 1'b0, rsp.hit);
		check_rdata("cold_miss", 16'h0000, rsp.rdata);
		cpu_access("warm_hit", 1'b0, 16'h0100, '0, rsp, cycles);
		check_hit("warm_hit", 1'b1, rsp.hit);
		check_cycles("warm_hit", 1, cycles);

		cpu_access("wr_fill", 1'b1, 16'h0200, 16'h1234, rsp, cycles);
		cpu_access("wr_word", 1'b1, 16'h0204, 16'hbeef, rsp, cycles);
		check_hit("wr_word", 1'b1, rsp.hit);
		cpu_access("rd_word", 1'b0, 16'h0204, '0, rsp, cycles);
		check_hit("rd_word", 1'b1, rsp.hit);
		check_rdata("rd_word", 16'hbeef, rsp.rdata);

		// Three tags into set 5
		cpu_access("evict_a", 1'b1, 16'h1028, 16'h1111, rsp, cycles);
		cpu_access("evict_b", 1'b1, 16'h2028, 16'h2222, rsp, cycles);
		cpu_access("evict_c", 1'b0, 16'h3028, '0, rsp, cycles);
		addr = line_cached(16'h1028) ? 16'h2028 : 16'h1028;
		data = line_cached(16'h1028) ? 16'h2222 : 16'h1111;
		cpu_access("evict_reread", 1'b0, addr, '0, rsp, cycles);
		check_hit("evict_reread", 1'b0, rsp.hit);
		check_rdata("evict_reread", data, rsp.rdata);

		for (int i = 0; i < `WORDS_PER_LINE; i++)
			cpu_access("offset_wr", 1'b1, 16'h4048 + 16'(2 * i), 16'ha000 + 16'(i), rsp, cycles);
		evict_tag = 8'h50;
		while (line_cached(16'h4048) && evict_tag < 8'h58) begin
			cpu_access("offset_evict", 1'b0, {evict_tag, 8'h48}, '0, rsp, cycles);
			// A hit flips the victim so the next miss picks the other way
			cpu_access("offset_touch", 1'b0, {evict_tag, 8'h48}, '0, rsp, cycles);
			evict_tag++;
		end
		if (line_cached(16'h4048)) begin
			$display("Line at 0x4048 stayed cached after eight conflicting reads");
			report_failure();
		end
		for (int i = 0; i < `WORDS_PER_LINE; i++) begin
			cpu_access("offset_rd", 1'b0, 16'h4048 + 16'(2 * i), '0, rsp, cycles);
			check_rdata("offset_rd", 16'ha000 + 16'(i), rsp.rdata);
		end

		// Small range, four tags over two sets
		for (int n = 0; n < 300; n++) begin
			addr = {TAG_W'($urandom_range(3)), INDEX_W'($urandom_range(1)),
				WSEL_W'($urandom_range(3)), 1'b0};
			wr   = $urandom_range(1);
			data = $urandom;
			cpu_access("random", wr, addr, data, rsp, cycles);
		end

		@(negedge clk);   // Let the monitor take the last response
		if (exp_q.size() != 0 || u_dut.u_ctrl.u_checker.fail_count != 0) begin
			$display("Run ended with %0d unchecked responses or a failed assertion",
				exp_q.size());
			report_failure();
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule
